// File: common/mboxPkg.sv
`default_nettype none

package mboxPkg;

  // Hold queue entries, also the core's starting credit count
  localparam int REQ_DEPTH = 2;

  // Cycles per memory phase
  localparam int PHASE_LEN = 4;

  // Memory data valid to cache write
  localparam int DATA_DELAY = 2;

  localparam int REQ_PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);
  localparam int PHASE_CNT_W = (PHASE_LEN > 1) ? $clog2(PHASE_LEN) : 1;

  // One 36-bit memory word
  typedef logic [35:0] wordT;

  // Cache line number, address bits 27 to 33
  typedef logic [6:0] lineAdrT;

  // Word within the quad, address bits 34 and 35
  typedef logic [1:0] wordSelT;

  // Bit i asks for word i of the quad
  typedef logic [3:0] rqMaskT;

  typedef enum logic {
    phaseA,
    phaseB
  } phaseT;

  typedef enum logic [1:0] {
    idle,
    waitPhase,
    running,
    waitRelease
  } startStateT;

endpackage

`default_nettype wire

// File: logic/acknTracker.sv
`timescale 1ns/1ps
`default_nettype none

module acknTracker
  import mboxPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    cycleLoad,
  input  wordSelT cycleWordSel,
  input  rqMaskT  cycleMask,
  input  logic    cycleRead,
  input  logic    memAckn,
  input  logic    memDataValid,
  input  wordT    memRdData,
  output logic    lastAckn,
  output logic    wordValid,
  output wordSelT wordIdx,
  output wordT    wordData
);

  // Requests still owed an acknowledge
  rqMaskT ackLeft;
  rqMaskT ackRest;

  // Read words still owed a data pulse
  rqMaskT  dataLeft;
  wordSelT wordPtr;
  wordSelT hitIdx;
  logic    hitFound;

  // Drop the lowest set bit on each acknowledge
  assign ackRest  = ackLeft & (ackLeft - 1'b1);
  assign lastAckn = memAckn && (ackLeft != '0) && (ackRest == '0);

  // Next wanted word in wrap order from the word pointer
  always_comb begin
    wordSelT probe;
    hitIdx   = wordPtr;
    hitFound = 1'b0;
    for (int i = 0; i < $bits(rqMaskT); i++) begin
      probe = wordPtr + wordSelT'(i);
      if (!hitFound && dataLeft[probe]) begin
        hitIdx   = probe;
        hitFound = 1'b1;
      end
    end
  end

  assign wordValid = memDataValid && hitFound;
  assign wordIdx   = hitIdx;
  assign wordData  = memRdData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ackLeft  <= '0;
      dataLeft <= '0;
      wordPtr  <= '0;
    end else if (cycleLoad) begin
      ackLeft  <= cycleMask;
      // Writes bring back no data
      dataLeft <= cycleRead ? cycleMask : '0;
      wordPtr  <= cycleWordSel;
    end else begin
      if (memAckn) begin
        ackLeft <= ackRest;
      end
      if (wordValid) begin
        dataLeft[hitIdx] <= 1'b0;
        wordPtr          <= hitIdx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cacheWriter.sv
`timescale 1ns/1ps
`default_nettype none

module cacheWriter
  import mboxPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    cycleLoad,
  input  lineAdrT cycleLine,
  input  logic    wordValid,
  input  wordSelT wordIdx,
  input  wordT    wordData,
  output logic    cacheWrEn,
  output lineAdrT cacheWrLine,
  output wordSelT cacheWrWord,
  output wordT    cacheWrData,
  output logic    coreDataValid,
  output wordT    coreData
);

  lineAdrT lineHold;
  logic    firstPending;

  // T1 is the arriving word, later entries are T2 and T3
  logic    validPipe [DATA_DELAY];
  logic    firstPipe [DATA_DELAY];
  wordSelT idxPipe [DATA_DELAY];
  wordT    dataPipe [DATA_DELAY];
  lineAdrT linePipe [DATA_DELAY];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      firstPending <= 1'b0;
      for (int i = 0; i < DATA_DELAY; i++) begin
        validPipe[i] <= 1'b0;
        firstPipe[i] <= 1'b0;
      end
    end else begin
      if (cycleLoad) begin
        firstPending <= 1'b1;
      end else if (wordValid) begin
        firstPending <= 1'b0;
      end
      validPipe[0] <= wordValid;
      firstPipe[0] <= wordValid && firstPending;
      for (int i = 1; i < DATA_DELAY; i++) begin
        validPipe[i] <= validPipe[i-1];
        firstPipe[i] <= firstPipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cycleLoad) begin
      lineHold <= cycleLine;
    end
    // Line rides along in case the next cycle loads before the write
    idxPipe[0]  <= wordIdx;
    dataPipe[0] <= wordData;
    linePipe[0] <= lineHold;
    for (int i = 1; i < DATA_DELAY; i++) begin
      idxPipe[i]  <= idxPipe[i-1];
      dataPipe[i] <= dataPipe[i-1];
      linePipe[i] <= linePipe[i-1];
    end
  end

  assign cacheWrEn     = validPipe[DATA_DELAY-1];
  assign cacheWrLine   = linePipe[DATA_DELAY-1];
  assign cacheWrWord   = idxPipe[DATA_DELAY-1];
  assign cacheWrData   = dataPipe[DATA_DELAY-1];
  assign coreDataValid = firstPipe[DATA_DELAY-1];
  assign coreData      = dataPipe[DATA_DELAY-1];

endmodule

`default_nettype wire

// File: logic/mbox.sv
`timescale 1ns/1ps
`default_nettype none

module mbox
  import mboxPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    reqValid,
  input  lineAdrT reqLine,
  input  wordSelT reqWordSel,
  input  rqMaskT  reqMask,
  input  logic    reqRead,
  input  wordT    reqData,
  output logic    reqCredit,
  input  logic    forceBadPar,
  output logic    memStartA,
  output logic    memStartB,
  output lineAdrT memLine,
  output rqMaskT  memRq,
  output logic    memRead,
  output logic    memWrite,
  output wordT    memWrData,
  output logic    memAdrPar,
  input  logic    memAckn,
  input  logic    memDataValid,
  input  wordT    memRdData,
  output logic    cacheWrEn,
  output lineAdrT cacheWrLine,
  output wordSelT cacheWrWord,
  output wordT    cacheWrData,
  output logic    coreDataValid,
  output wordT    coreData
);

  logic    issueValid;
  lineAdrT issueLine;
  wordSelT issueWordSel;
  rqMaskT  issueMask;
  logic    issueRead;
  wordT    issueData;
  logic    startCredit;

  logic    cycleLoad;
  lineAdrT cycleLine;
  wordSelT cycleWordSel;
  rqMaskT  cycleMask;
  logic    cycleRead;
  logic    lastAckn;

  logic    wordValid;
  wordSelT wordIdx;
  wordT    wordData;

  reqCapture uReqCapture (
    .clk          (clk),
    .arstN        (arstN),
    .reqValid     (reqValid),
    .reqLine      (reqLine),
    .reqWordSel   (reqWordSel),
    .reqMask      (reqMask),
    .reqRead      (reqRead),
    .reqData      (reqData),
    .startCredit  (startCredit),
    .reqCredit    (reqCredit),
    .issueValid   (issueValid),
    .issueLine    (issueLine),
    .issueWordSel (issueWordSel),
    .issueMask    (issueMask),
    .issueRead    (issueRead),
    .issueData    (issueData)
  );

  memStartCtl uMemStartCtl (
    .clk          (clk),
    .arstN        (arstN),
    .issueValid   (issueValid),
    .issueLine    (issueLine),
    .issueWordSel (issueWordSel),
    .issueMask    (issueMask),
    .issueRead    (issueRead),
    .issueData    (issueData),
    .forceBadPar  (forceBadPar),
    .lastAckn     (lastAckn),
    .startCredit  (startCredit),
    .memStartA    (memStartA),
    .memStartB    (memStartB),
    .memLine      (memLine),
    .memRq        (memRq),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memWrData    (memWrData),
    .memAdrPar    (memAdrPar),
    .cycleLoad    (cycleLoad),
    .cycleLine    (cycleLine),
    .cycleWordSel (cycleWordSel),
    .cycleMask    (cycleMask),
    .cycleRead    (cycleRead)
  );

  acknTracker uAcknTracker (
    .clk          (clk),
    .arstN        (arstN),
    .cycleLoad    (cycleLoad),
    .cycleWordSel (cycleWordSel),
    .cycleMask    (cycleMask),
    .cycleRead    (cycleRead),
    .memAckn      (memAckn),
    .memDataValid (memDataValid),
    .memRdData    (memRdData),
    .lastAckn     (lastAckn),
    .wordValid    (wordValid),
    .wordIdx      (wordIdx),
    .wordData     (wordData)
  );

  cacheWriter uCacheWriter (
    .clk           (clk),
    .arstN         (arstN),
    .cycleLoad     (cycleLoad),
    .cycleLine     (cycleLine),
    .wordValid     (wordValid),
    .wordIdx       (wordIdx),
    .wordData      (wordData),
    .cacheWrEn     (cacheWrEn),
    .cacheWrLine   (cacheWrLine),
    .cacheWrWord   (cacheWrWord),
    .cacheWrData   (cacheWrData),
    .coreDataValid (coreDataValid),
    .coreData      (coreData)
  );

endmodule

`default_nettype wire

// File: logic/memStartCtl.sv
`timescale 1ns/1ps
`default_nettype none

module memStartCtl
  import mboxPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    issueValid,
  input  lineAdrT issueLine,
  input  wordSelT issueWordSel,
  input  rqMaskT  issueMask,
  input  logic    issueRead,
  input  wordT    issueData,
  input  logic    forceBadPar,
  input  logic    lastAckn,
  output logic    startCredit,
  output logic    memStartA,
  output logic    memStartB,
  output lineAdrT memLine,
  output rqMaskT  memRq,
  output logic    memRead,
  output logic    memWrite,
  output wordT    memWrData,
  output logic    memAdrPar,
  output logic    cycleLoad,
  output lineAdrT cycleLine,
  output wordSelT cycleWordSel,
  output rqMaskT  cycleMask,
  output logic    cycleRead
);

  logic [PHASE_CNT_W-1:0] phaseCnt;
  phaseT      curPhase;
  phaseT      comingPhase;
  logic       boundary;
  startStateT state;

  lineAdrT holdLine;
  wordSelT holdWordSel;
  rqMaskT  holdMask;
  logic    holdRead;
  wordT    holdData;
  logic    holdBadPar;

  // Boundary is the last cycle of the current phase
  assign boundary    = (phaseCnt == PHASE_CNT_W'(PHASE_LEN - 1));
  assign comingPhase = (curPhase == phaseA) ? phaseB : phaseA;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phaseCnt <= '0;
      curPhase <= phaseA;
    end else if (boundary) begin
      phaseCnt <= '0;
      curPhase <= comingPhase;
    end else begin
      phaseCnt <= phaseCnt + 1'b1;
    end
  end

  assign cycleLoad = (state == waitPhase) && boundary;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state       <= idle;
      memStartA   <= 1'b0;
      memStartB   <= 1'b0;
      startCredit <= 1'b0;
    end else begin
      startCredit <= 1'b0;
      case (state)
        idle: begin
          if (issueValid) begin
            state <= waitPhase;
          end
        end
        waitPhase: begin
          if (boundary) begin
            state     <= running;
            memStartA <= (comingPhase == phaseA);
            memStartB <= (comingPhase == phaseB);
          end
        end
        running: begin
          if (lastAckn) begin
            state <= waitRelease;
          end
        end
        waitRelease: begin
          if (boundary) begin
            state       <= idle;
            memStartA   <= 1'b0;
            memStartB   <= 1'b0;
            startCredit <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Holds only move while idle, so the bus is steady under start
  always_ff @(posedge clk) begin
    if (issueValid) begin
      holdLine    <= issueLine;
      holdWordSel <= issueWordSel;
      holdMask    <= issueMask;
      holdRead    <= issueRead;
      holdData    <= issueData;
    end
    if (cycleLoad) begin
      holdBadPar <= forceBadPar;
    end
  end

  assign memLine   = holdLine;
  assign memRq     = holdMask;
  assign memRead   = holdRead;
  assign memWrite  = !holdRead;
  assign memWrData = holdData;

  assign memAdrPar = (^holdLine) ^ (^holdWordSel) ^ (^holdMask) ^
                     holdRead ^ memWrite ^ holdBadPar;

  assign cycleLine    = holdLine;
  assign cycleWordSel = holdWordSel;
  assign cycleMask    = holdMask;
  assign cycleRead    = holdRead;

endmodule

`default_nettype wire

// File: logic/reqCapture.sv
`timescale 1ns/1ps
`default_nettype none

module reqCapture
  import mboxPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    reqValid,
  input  lineAdrT reqLine,
  input  wordSelT reqWordSel,
  input  rqMaskT  reqMask,
  input  logic    reqRead,
  input  wordT    reqData,
  input  logic    startCredit,
  output logic    reqCredit,
  output logic    issueValid,
  output lineAdrT issueLine,
  output wordSelT issueWordSel,
  output rqMaskT  issueMask,
  output logic    issueRead,
  output wordT    issueData
);

  lineAdrT qLine [REQ_DEPTH];
  wordSelT qWordSel [REQ_DEPTH];
  rqMaskT  qMask [REQ_DEPTH];
  logic    qRead [REQ_DEPTH];
  wordT    qData [REQ_DEPTH];

  logic [REQ_PTR_W-1:0] wrPtr;
  logic [REQ_PTR_W-1:0] rdPtr;
  logic [REQ_CNT_W-1:0] count;

  // Single credit toward the start stage
  logic downCredit;

  function automatic logic [REQ_PTR_W-1:0] bumpPtr(input logic [REQ_PTR_W-1:0] ptr);
    return (ptr == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign issueValid = (count != '0) && downCredit;

  // Every pop frees one slot back to the core
  assign reqCredit = issueValid;

  assign issueLine    = qLine[rdPtr];
  assign issueWordSel = qWordSel[rdPtr];
  assign issueMask    = qMask[rdPtr];
  assign issueRead    = qRead[rdPtr];
  assign issueData    = qData[rdPtr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      downCredit <= 1'b1;
    end else begin
      if (reqValid) begin
        wrPtr <= bumpPtr(wrPtr);
      end
      if (issueValid) begin
        rdPtr <= bumpPtr(rdPtr);
      end
      case ({reqValid, issueValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (startCredit) begin
        downCredit <= 1'b1;
      end else if (issueValid) begin
        downCredit <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid) begin
      qLine[wrPtr]    <= reqLine;
      qWordSel[wrPtr] <= reqWordSel;
      qMask[wrPtr]    <= reqMask;
      qRead[wrPtr]    <= reqRead;
      qData[wrPtr]    <= reqData;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbMbox -f src.f -o simMbox > build.log 2>&1 \
  && ./obj_dir/simMbox > sim.log 2>&1 \
  || { echo "Build or simulation did not run"; cat build.log; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// File: src.f
common/mboxPkg.sv
logic/reqCapture.sv
logic/memStartCtl.sv
logic/acknTracker.sv
logic/cacheWriter.sv
logic/mbox.sv
test/mboxChecker.sv
test/tbMbox.sv

// File: test/mboxChecker.sv
`timescale 1ns/1ps
`default_nettype none

module mboxChecker
  import mboxPkg::*;
(
  input wire logic    clk,
  input wire logic    arstN,
  input wire logic    reqValid,
  input wire lineAdrT reqLine,
  input wire wordSelT reqWordSel,
  input wire rqMaskT  reqMask,
  input wire logic    reqRead,
  input wire wordT    reqData,
  input wire logic    reqCredit,
  input wire logic    forceBadPar,
  input wire logic    memStartA,
  input wire logic    memStartB,
  input wire lineAdrT memLine,
  input wire rqMaskT  memRq,
  input wire logic    memRead,
  input wire logic    memWrite,
  input wire wordT    memWrData,
  input wire logic    memAdrPar,
  input wire logic    memAckn,
  input wire logic    memDataValid,
  input wire logic    cacheWrEn,
  input wire lineAdrT cacheWrLine,
  input wire wordSelT cacheWrWord,
  input wire wordT    cacheWrData,
  input wire logic    coreDataValid,
  input wire wordT    coreData
);

  int mismatchCount = 0;
  int faultCount = 0;
  int acceptedCount = 0;
  int startedCount = 0;
  int creditCount = 0;
  int writesOwed = 0;
  int cycleCnt = 0;

  // Requests accepted but not yet started
  lineAdrT pLine [$];
  wordSelT pWs [$];
  rqMaskT  pMask [$];
  logic    pRead [$];
  wordT    pData [$];

  lineAdrT curLine;
  wordSelT curWs;
  rqMaskT  curMask;
  logic    curRead = 1'b0;
  wordT    curData;
  logic    curPar;
  logic    inCycle = 1'b0;
  logic    firstDone;
  logic    lastForce = 1'b0;
  int      acksSeen;
  int      linger;

  // Cycle and phase of the first start
  int      phaseRef = -1;
  logic    refB = 1'b0;

  wordSelT idxQ [$];

  // Predicted cache writes
  int      wDue [$];
  lineAdrT wLine [$];
  wordSelT wIdx [$];
  logic    wFirst [$];

  function automatic wordT expectedWord(input lineAdrT line, input wordSelT w);
    return {line, w, line, w, line, w, line, w} ^ 36'h5A5A5A5A5;
  endfunction

  function automatic int countBits(input rqMaskT m);
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic reportMismatch(input string sig, input logic [35:0] got,
                                input logic [35:0] exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
    mismatchCount++;
  endtask

  task automatic reportFault(input string msg);
    $display("Error at %0t: %s", $time, msg);
    faultCount++;
  endtask

  task automatic checkBus();
    if (memLine !== curLine) reportMismatch("memLine", 36'(memLine), 36'(curLine));
    if (memRq !== curMask) reportMismatch("memRq", 36'(memRq), 36'(curMask));
    if (memRead !== curRead) reportMismatch("memRead", 36'(memRead), 36'(curRead));
    if (memWrite !== !curRead) reportMismatch("memWrite", 36'(memWrite), 36'(!curRead));
    if (!curRead && memWrData !== curData) begin
      reportMismatch("memWrData", memWrData, curData);
    end
    if (memAdrPar !== curPar) reportMismatch("memAdrPar", 36'(memAdrPar), 36'(curPar));
  endtask

  always @(posedge clk) begin
    logic startHigh;
    logic expB;
    wordSelT q;
    if (arstN) begin
      cycleCnt++;
      startHigh = memStartA | memStartB;
      if (reqValid) begin
        pLine.push_back(reqLine);
        pWs.push_back(reqWordSel);
        pMask.push_back(reqMask);
        pRead.push_back(reqRead);
        pData.push_back(reqData);
        acceptedCount++;
      end
      if (reqCredit) begin
        creditCount++;
        if (creditCount > acceptedCount) begin
          reportFault("more credits returned than requests accepted");
        end
      end
      if (memStartA && memStartB) begin
        reportFault("memStartA and memStartB are high together");
      end

      if (startHigh && !inCycle) begin
        // Boundaries come every PHASE_LEN cycles and alternate A and B
        if (phaseRef < 0) begin
          phaseRef = cycleCnt;
          refB = memStartB;
        end else if ((cycleCnt - phaseRef) % PHASE_LEN != 0) begin
          reportFault("memory start rose off a phase boundary");
        end else begin
          expB = refB ^ ((cycleCnt - phaseRef) / PHASE_LEN % 2 == 1);
          if (memStartB !== expB) begin
            reportMismatch("memStartB", 36'(memStartB), 36'(expB));
          end
        end
        if (pLine.size() == 0) begin
          reportFault("memory start with no request waiting");
        end else begin
          curLine = pLine.pop_front();
          curWs = pWs.pop_front();
          curMask = pMask.pop_front();
          curRead = pRead.pop_front();
          curData = pData.pop_front();
          curPar = (^curLine) ^ (^curWs) ^ (^curMask) ^ curRead ^ !curRead ^ lastForce;
          inCycle = 1'b1;
          startedCount++;
          acksSeen = 0;
          linger = 0;
          firstDone = 1'b0;
          idxQ.delete();
          if (curRead) begin
            for (int i = 0; i < 4; i++) begin
              q = curWs + wordSelT'(i);
              if (curMask[q]) begin
                idxQ.push_back(q);
              end
            end
          end
        end
      end

      if (startHigh && inCycle) begin
        checkBus();
        if (acksSeen == countBits(curMask)) begin
          linger++;
          if (linger == PHASE_LEN + 1) begin
            reportFault("start still high too long after the last acknowledge");
          end
        end
        if (memAckn) begin
          acksSeen++;
          if (acksSeen > countBits(curMask)) begin
            reportFault("more acknowledges than requested words");
          end
        end
      end else if (memAckn) begin
        reportFault("acknowledge outside a memory cycle");
      end

      if (!startHigh && inCycle) begin
        if (acksSeen != countBits(curMask)) begin
          reportFault("start dropped before every word was acknowledged");
        end
        if ((cycleCnt - phaseRef) % PHASE_LEN != 0) begin
          reportFault("memory start fell off a phase boundary");
        end
        inCycle = 1'b0;
      end

      // Writes due this cycle
      if (cacheWrEn) begin
        if (wDue.size() == 0) begin
          reportFault("cache write with no read data pending");
        end else begin
          if (wDue[0] != cycleCnt) begin
            reportFault("cache write at the wrong cycle");
          end
          if (cacheWrLine !== wLine[0]) begin
            reportMismatch("cacheWrLine", 36'(cacheWrLine), 36'(wLine[0]));
          end
          if (cacheWrWord !== wIdx[0]) begin
            reportMismatch("cacheWrWord", 36'(cacheWrWord), 36'(wIdx[0]));
          end
          if (cacheWrData !== expectedWord(wLine[0], wIdx[0])) begin
            reportMismatch("cacheWrData", cacheWrData, expectedWord(wLine[0], wIdx[0]));
          end
          if (coreDataValid !== wFirst[0]) begin
            reportMismatch("coreDataValid", 36'(coreDataValid), 36'(wFirst[0]));
          end
          if (wFirst[0] && coreData !== expectedWord(wLine[0], wIdx[0])) begin
            reportMismatch("coreData", coreData, expectedWord(wLine[0], wIdx[0]));
          end
          void'(wDue.pop_front());
          void'(wLine.pop_front());
          void'(wIdx.pop_front());
          void'(wFirst.pop_front());
        end
      end else begin
        if (coreDataValid) begin
          reportFault("coreDataValid without a cache write");
        end
        if (wDue.size() != 0 && wDue[0] <= cycleCnt) begin
          reportFault("expected cache write did not happen");
          void'(wDue.pop_front());
          void'(wLine.pop_front());
          void'(wIdx.pop_front());
          void'(wFirst.pop_front());
        end
      end

      if (memDataValid) begin
        if (!curRead || idxQ.size() == 0) begin
          reportFault("read data with no read word outstanding");
        end else begin
          wDue.push_back(cycleCnt + DATA_DELAY);
          wLine.push_back(curLine);
          wIdx.push_back(idxQ.pop_front());
          wFirst.push_back(!firstDone);
          firstDone = 1'b1;
        end
      end

      writesOwed = wDue.size();
      lastForce = forceBadPar;
    end
  end

endmodule

`default_nettype wire

// File: test/tbMbox.sv
`timescale 1ns/1ps
`default_nettype none

module tbMbox
  import mboxPkg::*;
();

  localparam int NUM_REQS = 200;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 60 + 16;

  logic    clk = 1'b0;
  logic    arstN = 1'b0;
  logic    reqValid = 1'b0;
  lineAdrT reqLine = '0;
  wordSelT reqWordSel = '0;
  rqMaskT  reqMask = '0;
  logic    reqRead = 1'b0;
  wordT    reqData = '0;
  logic    forceBadPar = 1'b0;
  logic    memAckn = 1'b0;
  logic    memDataValid = 1'b0;
  wordT    memRdData = '0;

  logic    reqCredit;
  logic    memStartA;
  logic    memStartB;
  lineAdrT memLine;
  rqMaskT  memRq;
  logic    memRead;
  logic    memWrite;
  wordT    memWrData;
  logic    memAdrPar;
  logic    cacheWrEn;
  lineAdrT cacheWrLine;
  wordSelT cacheWrWord;
  wordT    cacheWrData;
  logic    coreDataValid;
  wordT    coreData;

  integer seed = 32'h456f5d21;
  int credits = REQ_DEPTH;
  int sentCount = 0;
  int cycleCount = 0;
  int endErrors = 0;

  // Word selects in send order
  wordSelT wsQ [$];
  logic    busy = 1'b0;
  int      acksLeft = 0;
  int      delay = 0;
  wordSelT nextIdx = '0;

  mbox dut (.*);

  mboxChecker chk (.*);

  function automatic wordT readWord(input lineAdrT line, input wordSelT w);
    return {line, w, line, w, line, w, line, w} ^ 36'h5A5A5A5A5;
  endfunction

  // First wanted word at or after from in wrap order
  function automatic wordSelT nextWanted(input rqMaskT m, input wordSelT from);
    wordSelT p;
    nextWanted = from;
    for (int i = 3; i >= 0; i--) begin
      p = from + wordSelT'(i);
      if (m[p]) begin
        nextWanted = p;
      end
    end
  endfunction

  function automatic int countBits(input rqMaskT m);
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  initial begin
    forever #10 clk = ~clk;
  end

  // Core model
  always @(posedge clk) begin
    wordSelT ws;
    if (arstN) begin
      if (reqCredit) begin
        credits++;
      end
      if (sentCount < NUM_REQS && credits > 0 && ({$random(seed)} % 4) != 0) begin
        ws = wordSelT'($random(seed));
        reqValid <= 1'b1;
        reqLine <= lineAdrT'($random(seed));
        reqWordSel <= ws;
        reqMask <= rqMaskT'(({$random(seed)} % 15) + 1);
        reqRead <= 1'($random(seed));
        reqData <= wordT'({$random(seed), $random(seed)});
        wsQ.push_back(ws);
        credits--;
        sentCount++;
      end else begin
        reqValid <= 1'b0;
      end
      forceBadPar <= (({$random(seed)} % 8) == 0);
    end
  end

  // Memory responder
  always @(posedge clk) begin
    logic startHigh;
    if (arstN) begin
      startHigh = memStartA | memStartB;
      memAckn <= 1'b0;
      memDataValid <= 1'b0;
      if (startHigh && !busy) begin
        busy = 1'b1;
        acksLeft = countBits(memRq);
        nextIdx = nextWanted(memRq, wsQ.pop_front());
        delay = {$random(seed)} % 7;
      end
      if (busy && startHigh && acksLeft > 0) begin
        if (delay == 0) begin
          memAckn <= 1'b1;
          if (memRead) begin
            memDataValid <= 1'b1;
            memRdData <= readWord(memLine, nextIdx);
          end
          nextIdx = nextWanted(memRq, nextIdx + 1'b1);
          acksLeft--;
          delay = {$random(seed)} % 7;
        end else begin
          delay--;
        end
      end
      if (!startHigh) begin
        busy = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    while (!(sentCount == NUM_REQS && chk.startedCount == NUM_REQS &&
             credits == REQ_DEPTH && chk.writesOwed == 0 &&
             !memStartA && !memStartB)) begin
      @(posedge clk);
    end
    repeat (DATA_DELAY + 4) @(posedge clk);
    if (chk.acceptedCount != NUM_REQS) begin
      $display("Error: checker saw %0d requests instead of %0d",
               chk.acceptedCount, NUM_REQS);
      endErrors++;
    end
    if (chk.creditCount != chk.acceptedCount) begin
      $display("Error: %0d credits returned for %0d requests",
               chk.creditCount, chk.acceptedCount);
      endErrors++;
    end
    $display("Errors: mismatches %0d, other checks %0d, end checks %0d",
             chk.mismatchCount, chk.faultCount, endErrors);
    if (chk.mismatchCount == 0 && chk.faultCount == 0 && endErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
